// ==== src.f ====
+incdir+test
hw/tnet_pkg.sv
hw/tnet_cmd_in.sv
hw/tnet_cmd_ctrl.sv
hw/tnet_net_params.sv
hw/tnet_tx_frame.sv
hw/tnet_node.sv
test/tnet_tb.sv

// ==== test/tnet_tb_tasks.svh ====
`ifndef TNET_TB_TASKS_SVH
`define TNET_TB_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// Checking

task automatic abort(input string msg);
   $display("%s", msg);
   $display("** FAIL **");
   $fatal(1, "simulation stopped");
endtask

task automatic check_eq(input string name, input logic [127:0] got,
                        input logic [127:0] exp);
   assert (got === exp) else
      abort($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
endtask

task automatic check_true(input logic cond, input string msg);
   assert (cond === 1'b1) else
      abort(msg);
endtask

task automatic check_params();
   check_eq("node_id_o", node_id_o, exp_id);
   check_eq("nn_o", nn_o, exp_nn);
   check_eq("rtd_o", rtd_o, exp_rtd);
   check_eq("cd_o", cd_o, exp_cd);
   check_eq("time_off_o", time_off_o, exp_off);
   check_eq("dt0_o", dt0_o, exp_dt0);
   check_eq("dt1_o", dt1_o, exp_dt1);
endtask

// Oldest frame seen on the link against the expected one
task automatic pop_frame(input frame_t exp);
   frame_t got;
   check_true(sent_q.size() > 0, "an expected frame was never sent on the link");
   got = sent_q.pop_front();
   check_eq("tx_frame_o", got, exp);
endtask

////////////////////////////////////////////////////////////////////////////
// Frame model and drivers

function automatic word_t mk_hdr(input op_t op, input flags_t flg,
                                 input node_id_t dst, input node_id_t src);
   return {3'b000, op, flg, dst, src};
endfunction

task automatic clear_counts();
   init_cnt = 0;
   updt_cnt = 0;
   err_cnt  = 0;
   sent_q.delete();
endtask

task automatic drive_local(input op_t op, input word_t d1, input word_t d2,
                           input word_t d3);
   @(negedge t_clk);
   check_true(ready_o, "local command issued while ready_o was low");
   cmd_i = 1'b1;
   op_i  = op;
   dt1_i = d1;
   dt2_i = d2;
   dt3_i = d3;
   @(negedge t_clk);
   cmd_i = 1'b0;
endtask

task automatic drive_net(input frame_t f);
   @(negedge t_clk);
   rx_valid_i = 1'b1;
   rx_frame_i = f;
   @(negedge t_clk);
   rx_valid_i = 1'b0;
endtask

// Settle two cycles so trailing pulses are counted
task automatic wait_ready();
   int cyc;
   cyc = 0;
   while (!ready_o) begin
      @(negedge t_clk);
      cyc++;
      if (cyc >= 100)
         abort("ready_o did not return high after a command");
   end
   repeat (2) @(negedge t_clk);
   check_true(ready_o, "ready_o fell again without a new command");
endtask

task automatic wait_sent(input int n);
   int cyc;
   cyc = 0;
   while (sent_q.size() < n) begin
      @(negedge t_clk);
      cyc++;
      if (cyc >= 50)
         abort("no frame appeared on the link");
   end
endtask

task automatic expect_not_ready(input int cycles);
   repeat (cycles) begin
      @(negedge t_clk);
      check_true(!ready_o, "ready_o rose while a response was still awaited");
   end
endtask

// Link partner with a random ack delay
// The frame must hold while the ack is withheld
task automatic link_model();
   frame_t held;
   int     delay;
   forever begin
      @(negedge t_clk);
      if (tx_req_o) begin
         held = tx_frame_o;
         sent_q.push_back(held);
         delay = $unsigned($random(seed)) % 6 + hold_extra;
         repeat (delay) begin
            @(negedge t_clk);
            check_eq("tx_frame_o", tx_frame_o, held);
            check_true(tx_req_o, "tx_req_o dropped before tx_ack_i was raised");
         end
         tx_ack_i = 1'b1;
         do
            @(negedge t_clk);
         while (tx_req_o);
         tx_ack_i = 1'b0;
      end
   end
endtask

`endif

// ==== test/tnet_tb.sv ====
`timescale 1ns/1ps

module tnet_tb;
   import tnet_pkg::*;

   localparam int       CLK_PERIOD   = 8;
   localparam int       N_TESTS      = 7;
   localparam int       CYC_PER_TEST = 200;
   localparam node_id_t START_ID     = 9'h021;

   logic     t_clk = 1'b0;
   logic     t_aresetn;
   logic     cmd_i, rx_valid_i, tx_ack_i;
   op_t      op_i;
   word_t    dt1_i, dt2_i, dt3_i;
   frame_t   rx_frame_i, tx_frame_o;
   logic     ready_o, tx_req_o, time_init_o, time_updt_o, error_o;
   word_t    time_off_o, rtd_o, cd_o, dt0_o, dt1_o;
   node_id_t node_id_o, nn_o;

   // Expected parameter store
   node_id_t exp_id, exp_nn;
   word_t    exp_rtd, exp_cd, exp_off, exp_dt0, exp_dt1;

   frame_t sent_q[$];
   integer seed       = 32'hc440d109;
   int     hold_extra = 0;
   int     init_cnt   = 0;
   int     updt_cnt   = 0;
   int     err_cnt    = 0;

   always #(CLK_PERIOD / 2) t_clk = ~t_clk;

   tnet_node #(.RST_NODE_ID(START_ID)) dut0 (
      .t_clk(t_clk), .t_aresetn(t_aresetn),
      .cmd_i(cmd_i), .op_i(op_i), .dt1_i(dt1_i), .dt2_i(dt2_i), .dt3_i(dt3_i),
      .ready_o(ready_o), .rx_valid_i(rx_valid_i), .rx_frame_i(rx_frame_i),
      .tx_req_o(tx_req_o), .tx_frame_o(tx_frame_o), .tx_ack_i(tx_ack_i),
      .time_init_o(time_init_o), .time_updt_o(time_updt_o), .time_off_o(time_off_o),
      .node_id_o(node_id_o), .nn_o(nn_o), .rtd_o(rtd_o), .cd_o(cd_o),
      .dt0_o(dt0_o), .dt1_o(dt1_o), .error_o(error_o)
   );

   // Pulse counters
   always @(posedge t_clk) begin
      if (time_init_o)
         init_cnt++;
      if (time_updt_o)
         updt_cnt++;
      if (error_o)
         err_cnt++;
   end

   `include "tnet_tb_tasks.svh"

   ////////////////////////////////////////////////////////////////////////////
   // Network commands

   task automatic test_net_set_net();
      frame_t f;
      f = {mk_hdr(OP_SET_NET, 6'b110000, BROADCAST_ID, 9'h003),
           32'h0000_1234, 32'h0000_0040, {7'd0, 9'd12, 7'd0, 9'h0a5}};
      clear_counts();
      drive_net(f);
      wait_ready();
      exp_rtd = f[95:64];
      exp_cd  = f[63:32];
      exp_nn  = f[24:16];
      exp_id  = f[8:0];
      check_params();
      // Hop counter goes up by one on the way out
      f[8:0] = f[8:0] + 9'd1;
      pop_frame(f);
      check_eq("frames left", sent_q.size(), 0);
   endtask

   task automatic test_net_sync();
      word_t hdr, d1, d2;
      hdr = mk_hdr(OP_SYNC_NET, 6'b110000, BROADCAST_ID, 9'h003);
      d1  = 32'h0001_0000;
      d2  = 32'h0000_0100;
      clear_counts();
      drive_net({hdr, d1, d2, 32'h0000_0077});
      wait_ready();
      exp_off = d1 + d2;
      check_params();
      check_eq("time_init_o pulses", init_cnt, 1);
      pop_frame({hdr, d1 + exp_cd, d2, 32'h0});
   endtask

   task automatic test_net_updt_set_dt();
      clear_counts();
      drive_net({mk_hdr(OP_UPDT_OFF, 6'b0, exp_id, 9'h003),
                 32'h0bad_0001, 32'h0000_0005, 32'h0});
      wait_ready();
      exp_off = 32'h0bad_0001;
      check_eq("time_updt_o pulses", updt_cnt, 1);
      drive_net({mk_hdr(OP_SET_DT, 6'b0, exp_id, 9'h003),
                 32'h1111_aaaa, 32'h2222_bbbb, 32'h0});
      wait_ready();
      exp_dt0 = 32'h1111_aaaa;
      exp_dt1 = 32'h2222_bbbb;
      check_params();
      check_eq("frames sent", sent_q.size(), 0);
   endtask

   task automatic test_net_get_dt();
      clear_counts();
      drive_net({mk_hdr(OP_GET_DT, 6'b010000, exp_id, 9'h07e), {3{32'hffff_ffff}}});
      wait_ready();
      pop_frame({mk_hdr(OP_GET_DT, 6'b010001, 9'h07e, exp_id), exp_dt0, exp_dt1, 32'h0});
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Local commands

   task automatic test_loc_get_dt_resp();
      clear_counts();
      drive_local(OP_GET_DT, 32'h5, 32'h6, {7'd0, 9'h044, 16'h0});
      wait_sent(1);
      expect_not_ready(12);
      pop_frame({mk_hdr(OP_GET_DT, 6'b010000, 9'h044, exp_id), 96'd0});
      drive_net({mk_hdr(OP_GET_DT, 6'b010001, exp_id, 9'h044),
                 32'haaaa_0001, 32'hbbbb_0002, 32'h0});
      wait_ready();
      exp_dt0 = 32'haaaa_0001;
      exp_dt1 = 32'hbbbb_0002;
      check_params();
      check_eq("error_o pulses", err_cnt, 0);
      check_eq("frames left", sent_q.size(), 0);
   endtask

   task automatic test_loc_get_dt_bad();
      clear_counts();
      drive_local(OP_GET_DT, 32'h7, 32'h8, {7'd0, 9'h044, 16'h0});
      wait_sent(1);
      expect_not_ready(12);
      pop_frame({mk_hdr(OP_GET_DT, 6'b010000, 9'h044, exp_id), 96'd0});
      // Neither addressed to us nor our own echo
      drive_net({mk_hdr(OP_SET_DT, 6'b0, 9'h155, 9'h044), 32'hdead_0001, 64'd0});
      wait_ready();
      check_eq("error_o pulses", err_cnt, 1);
      check_params();
      check_eq("frames left", sent_q.size(), 0);
   endtask

   task automatic test_loc_cmds();
      word_t d3;
      d3 = {7'd0, 9'h033, 16'h0};
      clear_counts();
      drive_local(OP_SET_NET, 32'h1, 32'h2, 32'h3);
      wait_sent(1);
      expect_not_ready(12);
      pop_frame({mk_hdr(OP_SET_NET, 6'b110000, BROADCAST_ID, LOC_SRC_ID),
                 exp_rtd, exp_cd, {7'd0, exp_nn, 16'd2}});
      drive_net({mk_hdr(OP_SET_NET, 6'b110000, BROADCAST_ID, exp_id), 96'h0123_4567_89ab});
      wait_ready();
      drive_local(OP_SYNC_NET, 32'h4, 32'h5, 32'h6);
      wait_sent(1);
      expect_not_ready(12);
      pop_frame({mk_hdr(OP_SYNC_NET, 6'b110000, BROADCAST_ID, LOC_SRC_ID), exp_cd, 64'd0});
      drive_net({mk_hdr(OP_SYNC_NET, 6'b110000, BROADCAST_ID, exp_id), 96'h0777_0001});
      wait_ready();
      check_eq("time_init_o pulses", init_cnt, 0);
      // Link withholds the ack for a while
      hold_extra = 10;
      drive_local(OP_UPDT_OFF, 32'h0c0c_0001, 32'h0c0c_0002, d3);
      wait_ready();
      hold_extra = 0;
      pop_frame({mk_hdr(OP_UPDT_OFF, 6'b0, 9'h033, exp_id), 32'h0c0c_0001, 32'h0c0c_0002, d3});
      drive_local(OP_SET_DT, 32'h0d0d_0001, 32'h0d0d_0002, d3);
      wait_ready();
      pop_frame({mk_hdr(OP_SET_DT, 6'b0, 9'h033, exp_id), 32'h0d0d_0001, 32'h0d0d_0002, 32'h0});
      drive_local(5'b00111, 32'h0, 32'h0, d3);
      wait_ready();
      check_eq("error_o pulses", err_cnt, 1);
      check_eq("frames left", sent_q.size(), 0);
      check_params();
   endtask

   initial begin
      #(N_TESTS * CYC_PER_TEST * CLK_PERIOD);
      abort("watchdog expired before the tests finished");
   end

   initial begin
      t_aresetn  = 1'b0;
      cmd_i      = 1'b0;
      op_i       = '0;
      dt1_i      = '0;
      dt2_i      = '0;
      dt3_i      = '0;
      rx_valid_i = 1'b0;
      rx_frame_i = '0;
      tx_ack_i   = 1'b0;
      exp_id     = START_ID;
      exp_nn     = '0;
      exp_rtd    = '0;
      exp_cd     = '0;
      exp_off    = '0;
      exp_dt0    = '0;
      exp_dt1    = '0;
      repeat (5) @(negedge t_clk);
      t_aresetn = 1'b1;
      @(negedge t_clk);
      check_true(ready_o && !tx_req_o && !error_o, "outputs not idle after reset");
      check_params();
      fork
         link_model();
      join_none
      test_net_set_net();
      test_net_sync();
      test_net_updt_set_dt();
      test_net_get_dt();
      test_loc_get_dt_resp();
      test_loc_get_dt_bad();
      test_loc_cmds();
      $display("** PASS **");
      $finish;
   end

endmodule

// ==== hw/tnet_node.sv ====
`timescale 1ns/1ps

module tnet_node #(
   parameter tnet_pkg::node_id_t RST_NODE_ID = '0
) (
   input  logic               t_clk,
   input  logic               t_aresetn,
   // Local command port
   input  logic               cmd_i,
   input  tnet_pkg::op_t      op_i,
   input  tnet_pkg::word_t    dt1_i,
   input  tnet_pkg::word_t    dt2_i,
   input  tnet_pkg::word_t    dt3_i,
   output logic               ready_o,
   // Network link
   input  logic               rx_valid_i,
   input  tnet_pkg::frame_t   rx_frame_i,
   output logic               tx_req_o,
   output tnet_pkg::frame_t   tx_frame_o,
   input  logic               tx_ack_i,
   // Time control and parameters
   output logic               time_init_o,
   output logic               time_updt_o,
   output tnet_pkg::word_t    time_off_o,
   output tnet_pkg::node_id_t node_id_o,
   output tnet_pkg::node_id_t nn_o,
   output tnet_pkg::word_t    rtd_o,
   output tnet_pkg::word_t    cd_o,
   output tnet_pkg::word_t    dt0_o,
   output tnet_pkg::word_t    dt1_o,
   output logic               error_o
);
   import tnet_pkg::*;

   logic         pend_valid, pend_is_net, take, net_drop;
   word_t        pend_hdr, pend_dt1, pend_dt2, pend_dt3;
   logic         ld_net, ld_off_sum, ld_off, ld_dt;
   logic         time_init_req, time_updt_req;
   logic         send, tx_busy;
   payload_sel_t sel;

   tnet_cmd_in cmd_in0 (
      .t_clk(t_clk), .t_aresetn(t_aresetn),
      .cmd_i(cmd_i), .op_i(op_i), .dt1_i(dt1_i), .dt2_i(dt2_i), .dt3_i(dt3_i),
      .rx_valid_i(rx_valid_i), .rx_frame_i(rx_frame_i), .node_id_i(node_id_o),
      .take_i(take), .pend_valid_o(pend_valid), .pend_is_net_o(pend_is_net),
      .pend_hdr_o(pend_hdr), .pend_dt1_o(pend_dt1), .pend_dt2_o(pend_dt2),
      .pend_dt3_o(pend_dt3), .net_drop_o(net_drop)
   );

   tnet_cmd_ctrl cmd_ctrl0 (
      .t_clk(t_clk), .t_aresetn(t_aresetn),
      .pend_valid_i(pend_valid), .pend_is_net_i(pend_is_net), .pend_hdr_i(pend_hdr),
      .net_drop_i(net_drop), .node_id_i(node_id_o), .tx_busy_i(tx_busy),
      .take_o(take), .ld_net_o(ld_net), .ld_off_sum_o(ld_off_sum), .ld_off_o(ld_off),
      .ld_dt_o(ld_dt), .time_init_req_o(time_init_req), .time_updt_req_o(time_updt_req),
      .send_o(send), .sel_o(sel), .ready_o(ready_o), .error_o(error_o)
   );

   tnet_net_params #(.RST_NODE_ID(RST_NODE_ID)) net_params0 (
      .t_clk(t_clk), .t_aresetn(t_aresetn),
      .ld_net_i(ld_net), .ld_off_sum_i(ld_off_sum), .ld_off_i(ld_off), .ld_dt_i(ld_dt),
      .dt1_i(pend_dt1), .dt2_i(pend_dt2), .dt3_i(pend_dt3),
      .time_init_req_i(time_init_req), .time_updt_req_i(time_updt_req),
      .node_id_o(node_id_o), .nn_o(nn_o), .rtd_o(rtd_o), .cd_o(cd_o),
      .off_o(time_off_o), .dt0_o(dt0_o), .dt1_o(dt1_o),
      .time_init_o(time_init_o), .time_updt_o(time_updt_o)
   );

   tnet_tx_frame tx_frame0 (
      .t_clk(t_clk), .t_aresetn(t_aresetn),
      .send_i(send), .sel_i(sel), .hdr_i(pend_hdr),
      .dt1_i(pend_dt1), .dt2_i(pend_dt2), .dt3_i(pend_dt3),
      .node_id_i(node_id_o), .nn_i(nn_o), .rtd_i(rtd_o), .cd_i(cd_o),
      .dt0_i(dt0_o), .dt1_par_i(dt1_o), .tx_ack_i(tx_ack_i),
      .tx_req_o(tx_req_o), .tx_frame_o(tx_frame_o), .tx_busy_o(tx_busy)
   );

endmodule

// ==== hw/tnet_tx_frame.sv ====
`timescale 1ns/1ps

module tnet_tx_frame (
   input  logic                   t_clk,
   input  logic                   t_aresetn,
   input  logic                   send_i,
   input  tnet_pkg::payload_sel_t sel_i,
   input  tnet_pkg::word_t        hdr_i,
   input  tnet_pkg::word_t        dt1_i,
   input  tnet_pkg::word_t        dt2_i,
   input  tnet_pkg::word_t        dt3_i,
   input  tnet_pkg::node_id_t     node_id_i,
   input  tnet_pkg::node_id_t     nn_i,
   input  tnet_pkg::word_t        rtd_i,
   input  tnet_pkg::word_t        cd_i,
   input  tnet_pkg::word_t        dt0_i,
   input  tnet_pkg::word_t        dt1_par_i,
   input  logic                   tx_ack_i,
   output logic                   tx_req_o,
   output tnet_pkg::frame_t       tx_frame_o,
   output logic                   tx_busy_o
);
   import tnet_pkg::*;

   word_t hdr, w1, w2, w3;

   ////////////////////////////////////////////////////////////////////////////
   // Payload select
   always_comb begin
      hdr = hdr_i;
      w1  = '0;
      w2  = '0;
      w3  = '0;
      case (sel_i)
         PL_LOC_SET_NET: begin
            w1 = rtd_i;
            w2 = cd_i;
            w3 = {7'd0, nn_i, 16'd2};
         end
         PL_LOC_SYNC: w1 = cd_i;
         PL_LOC_PASS: begin
            w1 = dt1_i;
            w2 = dt2_i;
            w3 = dt3_i;
         end
         PL_LOC_SET_DT: begin
            w1 = dt1_i;
            w2 = dt2_i;
         end
         PL_LOC_GET_DT: ;
         // Hop counter in data 3 low bits
         PL_FWD_SET_NET: begin
            w1 = dt1_i;
            w2 = dt2_i;
            w3 = {dt3_i[31:9], dt3_i[8:0] + 9'd1};
         end
         PL_FWD_SYNC: begin
            w1 = dt1_i + cd_i;
            w2 = dt2_i;
         end
         // Answer goes back to the requester
         PL_GET_DT_ANS: begin
            hdr[HDR_FLG_LSB + FLG_ANS]   = 1'b1;
            hdr[HDR_DST_MSB:HDR_DST_LSB] = hdr_i[HDR_SRC_MSB:HDR_SRC_LSB];
            hdr[HDR_SRC_MSB:HDR_SRC_LSB] = node_id_i;
            w1 = dt0_i;
            w2 = dt1_par_i;
         end
         default: ;
      endcase
   end

   // Request drops after ack, busy lasts until the link releases ack
   always_ff @(posedge t_clk) begin
      if (!t_aresetn) begin
         tx_req_o  <= 1'b0;
         tx_busy_o <= 1'b0;
      end else if (send_i) begin
         tx_req_o  <= 1'b1;
         tx_busy_o <= 1'b1;
      end else if (tx_req_o && tx_ack_i) begin
         tx_req_o <= 1'b0;
      end else if (tx_busy_o && !tx_req_o && !tx_ack_i) begin
         tx_busy_o <= 1'b0;
      end
   end

   always_ff @(posedge t_clk) begin
      if (send_i)
         tx_frame_o <= {hdr, w1, w2, w3};
   end

   a_frame_hold: assert property (@(posedge t_clk) disable iff (!t_aresetn)
      tx_req_o |=> !tx_req_o || $stable(tx_frame_o));

endmodule

// ==== hw/tnet_net_params.sv ====
`timescale 1ns/1ps

module tnet_net_params #(
   parameter tnet_pkg::node_id_t RST_NODE_ID = '0
) (
   input  logic               t_clk,
   input  logic               t_aresetn,
   input  logic               ld_net_i,
   input  logic               ld_off_sum_i,
   input  logic               ld_off_i,
   input  logic               ld_dt_i,
   input  tnet_pkg::word_t    dt1_i,
   input  tnet_pkg::word_t    dt2_i,
   input  tnet_pkg::word_t    dt3_i,
   input  logic               time_init_req_i,
   input  logic               time_updt_req_i,
   output tnet_pkg::node_id_t node_id_o,
   output tnet_pkg::node_id_t nn_o,
   output tnet_pkg::word_t    rtd_o,
   output tnet_pkg::word_t    cd_o,
   output tnet_pkg::word_t    off_o,
   output tnet_pkg::word_t    dt0_o,
   output tnet_pkg::word_t    dt1_o,
   output logic               time_init_o,
   output logic               time_updt_o
);

   always_ff @(posedge t_clk) begin
      if (!t_aresetn) begin
         node_id_o   <= RST_NODE_ID;
         nn_o        <= '0;
         rtd_o       <= '0;
         cd_o        <= '0;
         off_o       <= '0;
         dt0_o       <= '0;
         dt1_o       <= '0;
         time_init_o <= 1'b0;
         time_updt_o <= 1'b0;
      end else begin
         time_init_o <= time_init_req_i;
         time_updt_o <= time_updt_req_i;
         // Network parameters travel in set_net data words
         if (ld_net_i) begin
            rtd_o     <= dt1_i;
            cd_o      <= dt2_i;
            nn_o      <= dt3_i[24:16];
            node_id_o <= dt3_i[8:0];
         end
         if (ld_off_sum_i)
            off_o <= dt1_i + dt2_i;
         if (ld_off_i)
            off_o <= dt1_i;
         if (ld_dt_i) begin
            dt0_o <= dt1_i;
            dt1_o <= dt2_i;
         end
      end
   end

   a_one_load: assert property (@(posedge t_clk) disable iff (!t_aresetn)
      $onehot0({ld_net_i, ld_off_sum_i, ld_off_i, ld_dt_i}));

endmodule

// ==== hw/tnet_cmd_ctrl.sv ====
`timescale 1ns/1ps

module tnet_cmd_ctrl (
   input  logic                   t_clk,
   input  logic                   t_aresetn,
   input  logic                   pend_valid_i,
   input  logic                   pend_is_net_i,
   input  tnet_pkg::word_t        pend_hdr_i,
   input  logic                   net_drop_i,
   input  tnet_pkg::node_id_t     node_id_i,
   input  logic                   tx_busy_i,
   output logic                   take_o,
   output logic                   ld_net_o,
   output logic                   ld_off_sum_o,
   output logic                   ld_off_o,
   output logic                   ld_dt_o,
   output logic                   time_init_req_o,
   output logic                   time_updt_req_o,
   output logic                   send_o,
   output tnet_pkg::payload_sel_t sel_o,
   output logic                   ready_o,
   output logic                   error_o
);
   import tnet_pkg::*;

   main_st_t st, st_nxt;
   logic     resp_r, resp_nxt, is_resp;
   op_t      op;
   flags_t   flg;
   node_id_t dst, src;

   assign op  = pend_hdr_i[HDR_OP_MSB:HDR_OP_LSB];
   assign flg = pend_hdr_i[HDR_FLG_MSB:HDR_FLG_LSB];
   assign dst = pend_hdr_i[HDR_DST_MSB:HDR_DST_LSB];
   assign src = pend_hdr_i[HDR_SRC_MSB:HDR_SRC_LSB];

   // Our own broadcast coming back, or an answer addressed to us
   assign is_resp = (src == node_id_i && flg[FLG_RESP_REQ]) ||
                    (dst == node_id_i && flg[FLG_ANS]);

   always_ff @(posedge t_clk) begin
      if (!t_aresetn) begin
         st     <= IDLE;
         resp_r <= 1'b0;
      end else begin
         st     <= st_nxt;
         resp_r <= resp_nxt;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Dispatch, execute and retire
   always_comb begin
      st_nxt          = st;
      resp_nxt        = resp_r;
      take_o          = 1'b0;
      ld_net_o        = 1'b0;
      ld_off_sum_o    = 1'b0;
      ld_off_o        = 1'b0;
      ld_dt_o         = 1'b0;
      time_init_req_o = 1'b0;
      time_updt_req_o = 1'b0;
      send_o          = 1'b0;
      sel_o           = PL_LOC_PASS;
      case (st)
         IDLE: if (pend_valid_i) begin
            st_nxt   = pend_is_net_i ? NET_EXEC : LOC_EXEC;
            resp_nxt = 1'b0;
         end
         WAIT_RESP: if (pend_valid_i) begin
            st_nxt   = NET_EXEC;
            resp_nxt = 1'b1;
         end
         LOC_EXEC: begin
            send_o = 1'b1;
            st_nxt = WAIT_TX_ACK;
            case (op)
               OP_SET_NET:  sel_o = PL_LOC_SET_NET;
               OP_SYNC_NET: sel_o = PL_LOC_SYNC;
               OP_UPDT_OFF: sel_o = PL_LOC_PASS;
               OP_SET_DT:   sel_o = PL_LOC_SET_DT;
               OP_GET_DT:   sel_o = PL_LOC_GET_DT;
               default: begin
                  send_o = 1'b0;
                  st_nxt = ERROR;
               end
            endcase
         end
         NET_EXEC: begin
            if (resp_r) begin
               if (is_resp && (op == OP_SET_NET || op == OP_SYNC_NET || op == OP_GET_DT)) begin
                  ld_dt_o = (op == OP_GET_DT);
                  take_o  = 1'b1;
                  st_nxt  = IDLE;
               end else begin
                  st_nxt = ERROR;
               end
            end else begin
               st_nxt = WAIT_TX_ACK;
               case (op)
                  OP_SET_NET: begin
                     ld_net_o = 1'b1;
                     send_o   = 1'b1;
                     sel_o    = PL_FWD_SET_NET;
                  end
                  OP_SYNC_NET: begin
                     time_init_req_o = 1'b1;
                     ld_off_sum_o    = 1'b1;
                     send_o          = 1'b1;
                     sel_o           = PL_FWD_SYNC;
                  end
                  OP_GET_DT: begin
                     send_o = 1'b1;
                     sel_o  = PL_GET_DT_ANS;
                  end
                  OP_UPDT_OFF: begin
                     ld_off_o        = 1'b1;
                     time_updt_req_o = 1'b1;
                     take_o          = 1'b1;
                     st_nxt          = IDLE;
                  end
                  OP_SET_DT: begin
                     ld_dt_o = 1'b1;
                     take_o  = 1'b1;
                     st_nxt  = IDLE;
                  end
                  default: st_nxt = ERROR;
               endcase
            end
         end
         // Transmitter picks up the request, then drains
         WAIT_TX_ACK: if (tx_busy_i) st_nxt = WAIT_TX_NACK;
         WAIT_TX_NACK: if (!tx_busy_i) begin
            take_o = 1'b1;
            if (!pend_is_net_i && flg[FLG_RESP_REQ])
               st_nxt = WAIT_RESP;
            else
               st_nxt = IDLE;
         end
         ERROR: begin
            take_o = 1'b1;
            st_nxt = IDLE;
         end
         default: st_nxt = IDLE;
      endcase
   end

   assign ready_o = (st == IDLE) && !pend_valid_i;
   assign error_o = (st == ERROR) || net_drop_i;

   // A new frame is only built once the link has finished with the last one
   a_send_idle_tx: assert property (@(posedge t_clk) disable iff (!t_aresetn)
      send_o |-> !tx_busy_i);

endmodule

// ==== hw/tnet_cmd_in.sv ====
`timescale 1ns/1ps

module tnet_cmd_in (
   input  logic               t_clk,
   input  logic               t_aresetn,
   input  logic               cmd_i,
   input  tnet_pkg::op_t      op_i,
   input  tnet_pkg::word_t    dt1_i,
   input  tnet_pkg::word_t    dt2_i,
   input  tnet_pkg::word_t    dt3_i,
   input  logic               rx_valid_i,
   input  tnet_pkg::frame_t   rx_frame_i,
   input  tnet_pkg::node_id_t node_id_i,
   input  logic               take_i,
   output logic               pend_valid_o,
   output logic               pend_is_net_o,
   output tnet_pkg::word_t    pend_hdr_o,
   output tnet_pkg::word_t    pend_dt1_o,
   output tnet_pkg::word_t    pend_dt2_o,
   output tnet_pkg::word_t    pend_dt3_o,
   output logic               net_drop_o
);
   import tnet_pkg::*;

   logic   loc_valid, net_valid, clr_loc, clr_net;
   word_t  loc_hdr_nxt, loc_hdr, loc_dt1, loc_dt2, loc_dt3;
   frame_t net_frame;

   // Local header fields
   flags_t   loc_flg;
   node_id_t loc_dst, loc_src;

   always_comb begin
      loc_flg = '0;
      loc_dst = dt3_i[24:16];
      loc_src = node_id_i;
      case (op_i)
         OP_SET_NET, OP_SYNC_NET: begin
            loc_flg = 6'b110000;
            loc_dst = BROADCAST_ID;
            loc_src = LOC_SRC_ID;
         end
         OP_GET_DT: loc_flg[FLG_RESP_REQ] = 1'b1;
         default: ;
      endcase
      loc_hdr_nxt = '0;
      loc_hdr_nxt[HDR_OP_MSB:HDR_OP_LSB]   = op_i;
      loc_hdr_nxt[HDR_FLG_MSB:HDR_FLG_LSB] = loc_flg;
      loc_hdr_nxt[HDR_DST_MSB:HDR_DST_LSB] = loc_dst;
      loc_hdr_nxt[HDR_SRC_MSB:HDR_SRC_LSB] = loc_src;
   end

   // Take retires whichever slot is on the output
   assign clr_loc = take_i & loc_valid;
   assign clr_net = take_i & ~loc_valid & net_valid;

   always_ff @(posedge t_clk) begin
      if (!t_aresetn) begin
         loc_valid  <= 1'b0;
         net_valid  <= 1'b0;
         net_drop_o <= 1'b0;
      end else begin
         net_drop_o <= rx_valid_i & net_valid & ~clr_net;
         if (cmd_i)
            loc_valid <= 1'b1;
         else if (clr_loc)
            loc_valid <= 1'b0;
         if (rx_valid_i & (~net_valid | clr_net))
            net_valid <= 1'b1;
         else if (clr_net)
            net_valid <= 1'b0;
      end
   end

   always_ff @(posedge t_clk) begin
      if (cmd_i) begin
         loc_hdr <= loc_hdr_nxt;
         loc_dt1 <= dt1_i;
         loc_dt2 <= dt2_i;
         loc_dt3 <= dt3_i;
      end
      if (rx_valid_i & (~net_valid | clr_net))
         net_frame <= rx_frame_i;
   end

   // Local slot wins
   assign pend_valid_o  = loc_valid | net_valid;
   assign pend_is_net_o = ~loc_valid & net_valid;
   assign pend_hdr_o    = loc_valid ? loc_hdr : net_frame[127:96];
   assign pend_dt1_o    = loc_valid ? loc_dt1 : net_frame[95:64];
   assign pend_dt2_o    = loc_valid ? loc_dt2 : net_frame[63:32];
   assign pend_dt3_o    = loc_valid ? loc_dt3 : net_frame[31:0];

   // Processor only strobes while the node reports ready
   a_no_loc_overrun: assert property (@(posedge t_clk) disable iff (!t_aresetn)
      cmd_i |-> !loc_valid);

endmodule

// ==== hw/tnet_pkg.sv ====
package tnet_pkg;

   // Field widths
   typedef logic [4:0]   op_t;
   typedef logic [8:0]   node_id_t;
   typedef logic [5:0]   flags_t;
   typedef logic [31:0]  word_t;
   // Header word, then data 1, 2 and 3, most significant first
   typedef logic [127:0] frame_t;

   // Operation codes
   localparam op_t OP_SET_NET  = 5'b00010;
   localparam op_t OP_SYNC_NET = 5'b01000;
   localparam op_t OP_UPDT_OFF = 5'b01001;
   localparam op_t OP_SET_DT   = 5'b01010;
   localparam op_t OP_GET_DT   = 5'b01011;

   localparam node_id_t BROADCAST_ID = '1;
   // Source of broadcast local commands
   localparam node_id_t LOC_SRC_ID   = 9'd1;

   // Bit positions inside the flag field
   localparam int FLG_RESP_REQ = 4;
   localparam int FLG_ANS      = 0;

   // Header layout, bits 31:29 stay zero
   localparam int HDR_OP_MSB  = 28;
   localparam int HDR_OP_LSB  = 24;
   localparam int HDR_FLG_MSB = 23;
   localparam int HDR_FLG_LSB = 18;
   localparam int HDR_DST_MSB = 17;
   localparam int HDR_DST_LSB = 9;
   localparam int HDR_SRC_MSB = 8;
   localparam int HDR_SRC_LSB = 0;

   typedef enum logic [2:0] {
      IDLE,
      LOC_EXEC,
      NET_EXEC,
      WAIT_RESP,
      WAIT_TX_ACK,
      WAIT_TX_NACK,
      ERROR
   } main_st_t;

   // Payload built by the transmit side
   typedef enum logic [2:0] {
      PL_LOC_SET_NET,
      PL_LOC_SYNC,
      PL_LOC_PASS,
      PL_LOC_SET_DT,
      PL_LOC_GET_DT,
      PL_FWD_SET_NET,
      PL_FWD_SYNC,
      PL_GET_DT_ANS
   } payload_sel_t;

endpackage
